/* common/md_pkg.sv */
package md_pkg;

    // ========================================
    // word widths
    // ========================================
    localparam int WORD_W = 26;           // default data word width.
    localparam int STEP_W = 5;            // holds up to 32 divide steps.

    typedef logic [WORD_W-1:0] word_t;    // operand, quotient, remainder or product half.
    typedef logic [WORD_W-1:0] mag_t;     // unsigned magnitude.
    typedef logic [STEP_W-1:0] step_t;    // step count.

    // ========================================
    // operations and sequencer states
    // ========================================
    typedef enum logic {
        OP_MUL = 1'b0,
        OP_DIV = 1'b1
    } op_t;

    typedef enum logic [2:0] {
        S_IDLE = 3'd0,                    // waiting for go.
        S_SIGN = 3'd1,                    // magnitudes formed, datapaths loaded.
        S_STEP = 3'd2,                    // one multiply pair or quotient bit per cycle.
        S_FIX  = 3'd3,                    // signs applied to results.
        S_DONE = 3'd4                     // fin to the request port.
    } seq_state_t;

endpackage

/* design/md_req_port.sv */
`timescale 1ns/1ps
`default_nettype none

module md_req_port #(
    parameter int WIDTH = md_pkg::WORD_W
) (
    input  logic          sim_clk,
    input  logic          arst_n,
    input  logic          req,
    input  md_pkg::op_t   op,
    input  md_pkg::word_t opa,
    input  md_pkg::word_t opb,
    input  logic          fin,
    input  md_pkg::word_t seq_hi,
    input  md_pkg::word_t seq_lo,
    input  logic          seq_zero,
    output logic          ack,
    output logic          go,
    output md_pkg::op_t   op_q,
    output md_pkg::word_t opa_q,
    output md_pkg::word_t opb_q,
    output md_pkg::word_t res_hi,
    output md_pkg::word_t res_lo,
    output logic          div_zero
);
    typedef enum logic [1:0] {
        P_IDLE  = 2'd0,
        P_BUSY  = 2'd1,
        P_ACKED = 2'd2
    } port_state_t;

    port_state_t state;
    logic        start;

    assign start = (state == P_IDLE) && req && !ack;
    assign ack   = (state == P_ACKED);    // registered through the state.

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= P_IDLE;
            go    <= 1'b0;
        end else begin
            go <= start;
            case (state)
                P_IDLE:  if (start) state <= P_BUSY;
                P_BUSY:  if (fin) state <= P_ACKED;
                P_ACKED: if (!req) state <= P_IDLE;
                default: state <= P_IDLE;
            endcase
        end
    end

    // operands held for the whole operation.
    always_ff @(posedge sim_clk) begin
        if (start) begin
            op_q  <= op;
            opa_q <= opa[WIDTH-1:0];
            opb_q <= opb[WIDTH-1:0];
        end
    end

    // results held while ack is high.
    always_ff @(posedge sim_clk) begin
        if (fin) begin
            res_hi   <= seq_hi;
            res_lo   <= seq_lo;
            div_zero <= seq_zero;
        end
    end

endmodule

`default_nettype wire

/* design/md_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module md_unit_top #(
    parameter int WIDTH = md_pkg::WORD_W
) (
    input  logic          sim_clk,
    input  logic          arst_n,
    input  logic          req,
    input  md_pkg::op_t   op,
    input  md_pkg::word_t opa,
    input  md_pkg::word_t opb,
    output logic          ack,
    output md_pkg::word_t res_hi,
    output md_pkg::word_t res_lo,
    output logic          div_zero
);
    import md_pkg::*;

    logic  go;
    logic  fin;
    logic  load;
    logic  step;
    logic  seq_zero;
    op_t   op_q;
    word_t opa_q;
    word_t opb_q;
    word_t seq_hi;
    word_t seq_lo;
    mag_t  mag_a;
    mag_t  mag_b;
    mag_t  mul_hi;
    mag_t  mul_lo;
    mag_t  div_quo;
    mag_t  div_rem;

    md_req_port #(.WIDTH(WIDTH)) port_i (
        .sim_clk(sim_clk), .arst_n(arst_n), .req(req), .op(op), .opa(opa), .opb(opb),
        .fin(fin), .seq_hi(seq_hi), .seq_lo(seq_lo), .seq_zero(seq_zero),
        .ack(ack), .go(go), .op_q(op_q), .opa_q(opa_q), .opb_q(opb_q),
        .res_hi(res_hi), .res_lo(res_lo), .div_zero(div_zero)
    );

    md_sequencer #(.WIDTH(WIDTH)) seq_i (
        .sim_clk(sim_clk), .arst_n(arst_n), .go(go), .op_q(op_q),
        .opa_q(opa_q), .opb_q(opb_q), .mul_hi(mul_hi), .mul_lo(mul_lo),
        .div_quo(div_quo), .div_rem(div_rem), .load(load), .step(step),
        .mag_a(mag_a), .mag_b(mag_b), .fin(fin), .seq_hi(seq_hi),
        .seq_lo(seq_lo), .seq_zero(seq_zero)
    );

    md_multiplier #(.WIDTH(WIDTH)) mul_i (
        .sim_clk(sim_clk), .arst_n(arst_n), .load(load), .step(step),
        .mag_a(mag_a), .mag_b(mag_b), .mul_hi(mul_hi), .mul_lo(mul_lo)
    );

    md_divider #(.WIDTH(WIDTH)) div_i (
        .sim_clk(sim_clk), .arst_n(arst_n), .load(load), .step(step),
        .mag_a(mag_a), .mag_b(mag_b), .div_quo(div_quo), .div_rem(div_rem)
    );

endmodule

`default_nettype wire

/* mult_div/md_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module md_divider #(
    parameter int WIDTH = md_pkg::WORD_W
) (
    input  logic         sim_clk,
    input  logic         arst_n,
    input  logic         load,
    input  logic         step,
    input  md_pkg::mag_t mag_a,
    input  md_pkg::mag_t mag_b,
    output md_pkg::mag_t div_quo,
    output md_pkg::mag_t div_rem
);
    import md_pkg::*;

    mag_t             prem;               // partial remainder.
    mag_t             quo;                // dividend bits out, quotient bits in.
    mag_t             dvs;
    logic [WIDTH:0]   shifted;
    logic [WIDTH+1:0] diff;
    logic             borrow;

    // ========================================
    // one restoring step
    // ========================================
    assign shifted = {prem, quo[WIDTH-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs};
    assign borrow  = diff[WIDTH+1];       // negative, keep shifted value.

    always_ff @(posedge sim_clk) begin
        if (load) begin
            dvs <= mag_b;
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            prem <= '0;
            quo  <= '0;
        end else if (load) begin
            prem <= '0;
            quo  <= mag_a;
        end else if (step) begin
            if (borrow) begin
                prem <= shifted[WIDTH-1:0];
                quo  <= {quo[WIDTH-2:0], 1'b0};
            end else begin
                prem <= diff[WIDTH-1:0];  // below the divisor, fits the word.
                quo  <= {quo[WIDTH-2:0], 1'b1};
            end
        end
    end

    assign div_quo = quo;
    assign div_rem = prem;

endmodule

`default_nettype wire

/* mult_div/md_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module md_multiplier #(
    parameter int WIDTH = md_pkg::WORD_W
) (
    input  logic         sim_clk,
    input  logic         arst_n,
    input  logic         load,
    input  logic         step,
    input  md_pkg::mag_t mag_a,
    input  md_pkg::mag_t mag_b,
    output md_pkg::mag_t mul_hi,
    output md_pkg::mag_t mul_lo
);
    import md_pkg::*;

    logic [2*WIDTH-1:0] acc;              // partial product over multiplier.
    mag_t               mcand;
    logic [WIDTH+1:0]   mcand3;
    logic [WIDTH+1:0]   addend;
    logic [WIDTH+1:0]   sum;

    // ========================================
    // radix-4 addend select
    // ========================================
    always_comb begin
        case (acc[1:0])
            2'd0:    addend = '0;
            2'd1:    addend = {2'b00, mcand};
            2'd2:    addend = {1'b0, mcand, 1'b0};
            default: addend = mcand3;
        endcase
    end

    // upper half stays below mcand, so four times fits in WIDTH+2
    assign sum = {2'b00, acc[2*WIDTH-1:WIDTH]} + addend;

    always_ff @(posedge sim_clk) begin
        if (load) begin
            mcand  <= mag_a;
            mcand3 <= {2'b00, mag_a} + {1'b0, mag_a, 1'b0};   // triple held for the run.
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (load) begin
            acc <= {{WIDTH{1'b0}}, mag_b};
        end else if (step) begin
            acc <= {sum, acc[WIDTH-1:2]};    // add then shift right by two.
        end
    end

    assign mul_hi = acc[2*WIDTH-1:WIDTH];
    assign mul_lo = acc[WIDTH-1:0];

endmodule

`default_nettype wire

/* mult_div/md_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module md_sequencer #(
    parameter int WIDTH = md_pkg::WORD_W
) (
    input  logic          sim_clk,
    input  logic          arst_n,
    input  logic          go,
    input  md_pkg::op_t   op_q,
    input  md_pkg::word_t opa_q,
    input  md_pkg::word_t opb_q,
    input  md_pkg::mag_t  mul_hi,
    input  md_pkg::mag_t  mul_lo,
    input  md_pkg::mag_t  div_quo,
    input  md_pkg::mag_t  div_rem,
    output logic          load,
    output logic          step,
    output md_pkg::mag_t  mag_a,
    output md_pkg::mag_t  mag_b,
    output logic          fin,
    output md_pkg::word_t seq_hi,
    output md_pkg::word_t seq_lo,
    output logic          seq_zero
);
    import md_pkg::*;

    seq_state_t         state;
    step_t              cnt;
    step_t              last_step;
    logic               sign_a;
    logic               sign_b;
    logic               neg_res;          // product or quotient negative.
    logic               neg_rem;          // remainder follows the dividend.
    logic               dz;
    logic [2*WIDTH-1:0] prod_mag;
    logic [2*WIDTH-1:0] prod_fix;
    word_t              quo_fix;
    word_t              rem_fix;

    // ========================================
    // sign gates and magnitudes
    // ========================================
    assign sign_a = opa_q[WIDTH-1];
    assign sign_b = opb_q[WIDTH-1];
    assign mag_a  = sign_a ? -opa_q : opa_q;   // most negative maps to 2**(WIDTH-1).
    assign mag_b  = sign_b ? -opb_q : opb_q;

    assign last_step = (op_q == OP_MUL) ? step_t'(WIDTH / 2 - 1) : step_t'(WIDTH - 1);

    assign load = (state == S_SIGN);
    assign step = (state == S_STEP);
    assign fin  = (state == S_DONE);

    // ========================================
    // state machine and step counter
    // ========================================
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            cnt     <= '0;
            neg_res <= 1'b0;
            neg_rem <= 1'b0;
            dz      <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (go) state <= S_SIGN;
                S_SIGN: begin
                    state   <= S_STEP;
                    cnt     <= '0;
                    neg_res <= sign_a ^ sign_b;
                    neg_rem <= sign_a;
                    dz      <= (op_q == OP_DIV) && (opb_q == '0);
                end
                S_STEP: begin
                    if (cnt == last_step) begin
                        state <= S_FIX;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_FIX:   state <= S_DONE;
                S_DONE:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // ========================================
    // result sign fix-up
    // ========================================
    // full double-length negate so the low word's carry reaches the high word
    assign prod_mag = {mul_hi, mul_lo};
    assign prod_fix = neg_res ? -prod_mag : prod_mag;
    assign quo_fix  = neg_res ? -div_quo : div_quo;
    assign rem_fix  = neg_rem ? -div_rem : div_rem;

    always_ff @(posedge sim_clk) begin
        if (state == S_FIX) begin
            if (dz) begin
                seq_hi <= '0;
                seq_lo <= '0;
            end else if (op_q == OP_MUL) begin
                seq_hi <= prod_fix[2*WIDTH-1:WIDTH];
                seq_lo <= prod_fix[WIDTH-1:0];
            end else begin
                seq_hi <= rem_fix;          // remainder high, quotient low.
                seq_lo <= quo_fix;
            end
            seq_zero <= dz;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_md_unit -f verilog.f -o tb_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no pass message in log"; exit 1; }
echo "simulation passed"

/* verification/tb_md_unit.sv */
`timescale 1ns/1ps

module tb_md_unit;
    import md_pkg::*;

    localparam int W              = WORD_W;
    localparam int N_MUL          = 120;
    localparam int N_DIV          = 120;
    localparam int N_ZERO         = 10;
    localparam int TIMEOUT_CYCLES = 300 * 40;   // operations times worst cycles each.

    logic        sim_clk;
    logic        arst_n;
    logic        req;
    op_t         op;
    word_t       opa;
    word_t       opb;
    logic        ack;
    word_t       res_hi;
    word_t       res_lo;
    logic        div_zero;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles;
    int          hold;
    word_t       a;
    word_t       b;

    md_unit_top #(.WIDTH(W)) dut_i (
        .sim_clk(sim_clk), .arst_n(arst_n), .req(req), .op(op), .opa(opa), .opb(opb),
        .ack(ack), .res_hi(res_hi), .res_lo(res_lo), .div_zero(div_zero)
    );

    initial begin
        sim_clk = 1'b0;
        forever #5 sim_clk = ~sim_clk;
    end

    // ========================================
    // stimulus helpers
    // ========================================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t pick_operand(input logic [31:0] r);
        word_t v;
        case (r[31:28])
            4'd0:    v = '0;
            4'd1:    v = word_t'(1);
            4'd2:    v = '1;                          // minus one.
            4'd3:    v = {1'b1, {(W-1){1'b0}}};       // most negative.
            4'd4:    v = {1'b0, {(W-1){1'b1}}};       // most positive.
            default: v = r[W-1:0];
        endcase
        return v;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ========================================
    // four-phase requester with model
    // ========================================
    task automatic run_op(input op_t o, input word_t x, input word_t y, input int extra);
        longint a_w;
        longint b_w;
        longint p_w;
        longint q_w;
        longint r_w;
        word_t  hi_s;
        word_t  lo_s;
        logic   dz_s;
        op  = o;
        opa = x;
        opb = y;
        req = 1'b1;
        @(posedge sim_clk);
        #1;
        while (!ack) begin
            @(posedge sim_clk);
            #1;
        end
        a_w = $signed(x);
        b_w = $signed(y);
        if (o == OP_MUL) begin
            p_w = a_w * b_w;
            check_value("product", {res_hi, res_lo}, p_w[2*W-1:0]);
            check_value("div_zero on multiply", div_zero, 0);
        end else if (b_w == 0) begin
            check_value("res_hi on divide by zero", res_hi, 0);
            check_value("res_lo on divide by zero", res_lo, 0);
            check_value("div_zero flag", div_zero, 1);
        end else begin
            q_w = a_w / b_w;                          // truncates toward zero.
            r_w = a_w % b_w;                          // takes the dividend's sign.
            check_value("quotient", res_lo, q_w[W-1:0]);
            check_value("remainder", res_hi, r_w[W-1:0]);
            check_value("div_zero on divide", div_zero, 0);
        end
        hi_s = res_hi;
        lo_s = res_lo;
        dz_s = div_zero;
        repeat (extra) begin
            @(posedge sim_clk);
            #1;
            check_value("ack held", ack, 1);
            check_value("res_hi held", res_hi, hi_s);
            check_value("res_lo held", res_lo, lo_s);
            check_value("div_zero held", div_zero, dz_s);
        end
        req = 1'b0;
        @(posedge sim_clk);
        #1;
        while (ack) begin
            @(posedge sim_clk);
            #1;
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge sim_clk);
            cycles++;
        end
        $display("timeout: handshake hung after %0d cycles", cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        req    = 1'b0;
        op     = OP_MUL;
        opa    = '0;
        opb    = '0;
        rng    = 32'hea69_1266;
        errors = 0;
        checks = 0;
        repeat (8) @(posedge sim_clk);
        #1;
        arst_n = 1'b1;
        check_value("ack after reset", ack, 0);
        @(posedge sim_clk);
        #1;
        check_value("ack idle", ack, 0);

        for (int i = 0; i < N_MUL; i++) begin
            rng  = xorshift(rng);
            a    = pick_operand(rng);
            rng  = xorshift(rng);
            b    = pick_operand(rng);
            rng  = xorshift(rng);
            hold = int'(rng % 6);
            run_op(OP_MUL, a, b, hold);
        end

        for (int i = 0; i < N_DIV; i++) begin
            rng  = xorshift(rng);
            a    = pick_operand(rng);
            rng  = xorshift(rng);
            b    = pick_operand(rng);
            if (b == '0) b = word_t'(7);              // nonzero divisor here.
            rng  = xorshift(rng);
            hold = int'(rng % 6);
            run_op(OP_DIV, a, b, hold);
        end

        // divide by zero, then a multiply clears the flag
        for (int i = 0; i < N_ZERO; i++) begin
            rng  = xorshift(rng);
            a    = pick_operand(rng);
            rng  = xorshift(rng);
            hold = int'(rng % 6);
            run_op(OP_DIV, a, '0, hold);
            rng  = xorshift(rng);
            b    = pick_operand(rng);
            run_op(OP_MUL, a, b, 0);
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
common/md_pkg.sv
design/md_req_port.sv
mult_div/md_sequencer.sv
mult_div/md_multiplier.sv
mult_div/md_divider.sv
design/md_unit_top.sv
verification/tb_md_unit.sv
